/* source/up_link_pkg.sv */
//**********************************************************
// processor side of the bridge, byte handshake definitions
// command packet is six bytes, reply packet is five bytes
// data bytes travel least significant first
// reserved command bits are ignored by the bridge
//**********************************************************

package up_link_pkg;

   localparam int CMD_BYTES     = 6;   // cmd, addr, four data bytes
   localparam int REPLY_BYTES   = 5;   // status, four data bytes

   localparam int CMD_BYTE_IDX    = 0;  // position in command packet
   localparam int ADDR_BYTE_IDX   = 1;
   localparam int DATA_BYTE_IDX   = 2;  // first of four, lsb first
   localparam int STATUS_BYTE_IDX = 0;  // position in reply packet

   typedef struct packed {
      logic       clear;      // bit 7, broadcast clear to all slaves
      logic [5:0] reserved;
      logic       write;      // bit 0, 1 = write, 0 = read
   } up_cmd_t;

   typedef enum logic [7:0] {
      STATUS_OK         = 8'h00,
      STATUS_TIMEOUT    = 8'h01,   // no slave answered
      STATUS_CLEAR_DONE = 8'h80
   } up_status_t;

   typedef enum logic [2:0] {
      IDLE,          // wait for up_start
      READ_BYTE,     // wait for handshake_1, sample byte
      WAIT_DROP,     // handshake_2 high until handshake_1 drops
      ISSUE,         // one cycle bus strobe
      WAIT_RSP,      // wait for response or timeout
      REPLY_BYTE,    // ack high, wait for handshake_1
      REPLY_DROP,    // reply byte on the pins
      DONE           // wait for up_start low
   } up_state_t;

endpackage

/* source/reg_bus_pkg.sv */
//**********************************************************
// internal 32-bit register bus, single cycle strobe
// no back-pressure, slaves answer in fixed time
// unmapped addresses are never answered, master times out
// a clear strobe is taken by all slaves and answered by none
//**********************************************************

package reg_bus_pkg;

   localparam int NUM_SLAVES    = 4;
   localparam int TIMEOUT_COUNT = 8;   // cycles in WAIT_RSP before giving up
   localparam int BUS_LATENCY   = 2;   // slave 1 + collector 1

   typedef struct packed {
      logic [3:0] slave;   // slave select
      logic [1:0] zero;    // must be zero to decode
      logic [1:0] index;   // register within slave
   } reg_addr_t;

   localparam logic [1:0] WCOUNT_INDEX = 2'd3;   // read-only write counter

   typedef enum logic [1:0] {
      BUS_READ  = 2'd0,
      BUS_WRITE = 2'd1,
      BUS_CLEAR = 2'd2
   } bus_op_t;

   typedef struct packed {
      logic        strobe;   // high for one cycle per transaction
      bus_op_t     op;
      reg_addr_t   addr;
      logic [31:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic        strobe;   // one cycle, BUS_LATENCY after request
      logic [31:0] rdata;
   } bus_rsp_t;

   typedef struct packed {
      logic        ack;      // one cycle after a decoded strobe
      logic [31:0] rdata;
   } slave_rsp_t;

endpackage

/* source/up_interface_fsm.sv */
//**********************************************************
// controller for the processor byte handshake
// four-phase: handshake_1 up, handshake_2 up, 1 down, 2 down
// dropping up_start while reading a packet aborts it
// reply bytes are only handed out while up_rw is low
//**********************************************************

module up_interface_fsm (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  up_start,
   input  logic                  up_handshake_1,
   input  logic                  up_rw,
   output logic                  up_handshake_2,
   output logic                  up_ack,
   input  logic                  counter_zero,    // all bytes of packet moved
   input  logic                  timeout_zero,    // wait for response expired
   input  up_link_pkg::up_cmd_t  cmd,
   input  logic                  rsp_strobe,
   output up_link_pkg::up_state_t state
);

   import up_link_pkg::*;

   up_state_t next_state;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (up_start) begin
               next_state = READ_BYTE;
            end
         end
         READ_BYTE: begin
            if (!up_start) begin
               next_state = IDLE;              // packet abandoned
            end else if (up_handshake_1) begin
               next_state = WAIT_DROP;         // byte sampled this cycle
            end
         end
         WAIT_DROP: begin
            if (!up_handshake_1) begin
               if (counter_zero) begin
                  next_state = ISSUE;          // whole command in
               end else begin
                  next_state = READ_BYTE;
               end
            end
         end
         ISSUE: begin
            if (cmd.clear) begin
               next_state = REPLY_BYTE;        // clear gets no bus reply
            end else begin
               next_state = WAIT_RSP;
            end
         end
         WAIT_RSP: begin
            if (rsp_strobe || timeout_zero) begin
               next_state = REPLY_BYTE;
            end
         end
         REPLY_BYTE: begin
            if (up_handshake_1 && !up_rw) begin
               next_state = REPLY_DROP;        // byte latched onto pins
            end
         end
         REPLY_DROP: begin
            if (!up_handshake_1) begin
               if (counter_zero) begin
                  next_state = DONE;
               end else begin
                  next_state = REPLY_BYTE;
               end
            end
         end
         DONE: begin
            if (!up_start) begin
               next_state = IDLE;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   // moore outputs, low in IDLE so low after reset
   assign up_handshake_2 = (state == WAIT_DROP) || (state == REPLY_DROP);
   assign up_ack         = (state == REPLY_BYTE) || (state == REPLY_DROP) ||
                           (state == DONE);

   // processor must still have been holding handshake_1 when we answered
   handshake_order_a : assert property (
      @(posedge clk) disable iff (!reset)
      $rose(up_handshake_2) |-> $past(up_handshake_1))
      else $error("handshake_2 rose without handshake_1 high");

endmodule

/* source/up_interface.sv */
//**********************************************************
// bridge master datapath, byte packets to one bus access
// up_data_out is valid while up_data_oe is high
// timeout and clear replies carry a zero data word
//**********************************************************

module up_interface (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   up_start,
   input  logic                   up_handshake_1,
   input  logic                   up_rw,
   input  logic [7:0]             up_data_in,
   output logic [7:0]             up_data_out,
   output logic                   up_data_oe,
   output logic                   up_ack,
   output logic                   up_handshake_2,
   output reg_bus_pkg::bus_req_t  bus_req,
   input  reg_bus_pkg::bus_rsp_t  bus_rsp
);

   import up_link_pkg::*;
   import reg_bus_pkg::*;

   localparam int COUNT_W   = $clog2(CMD_BYTES + 1);
   localparam int TIMEOUT_W = $clog2(TIMEOUT_COUNT + 1);

   logic [7:0]           cmd_packet   [CMD_BYTES];
   logic [7:0]           reply_packet [REPLY_BYTES];
   logic [7:0]           data_out_q;
   logic [COUNT_W-1:0]   byte_index;     // next byte in packet
   logic [COUNT_W-1:0]   bytes_left;
   logic [TIMEOUT_W-1:0] timeout_cnt;
   logic                 counter_zero;
   logic                 timeout_zero;
   logic                 byte_take;      // command byte sampled
   logic                 byte_give;      // reply byte handed out
   logic                 reply_load;
   up_cmd_t              cmd;
   up_state_t            state;
   up_status_t           reply_status;
   logic [31:0]          reply_word;

   up_interface_fsm u_fsm (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_rw          (up_rw),
      .up_handshake_2 (up_handshake_2),
      .up_ack         (up_ack),
      .counter_zero   (counter_zero),
      .timeout_zero   (timeout_zero),
      .cmd            (cmd),
      .rsp_strobe     (bus_rsp.strobe),
      .state          (state)
   );

   assign cmd          = up_cmd_t'(cmd_packet[CMD_BYTE_IDX]);
   assign byte_take    = (state == READ_BYTE) && up_handshake_1 && up_start;
   assign byte_give    = (state == REPLY_BYTE) && up_handshake_1 && !up_rw;
   assign reply_load   = ((state == ISSUE) && cmd.clear) ||
                         ((state == WAIT_RSP) && (bus_rsp.strobe || timeout_zero));
   assign counter_zero = (bytes_left == '0);
   assign timeout_zero = (timeout_cnt == '0);

   always_comb begin
      if (cmd.clear) begin
         reply_status = STATUS_CLEAR_DONE;
         reply_word   = '0;
      end else if (bus_rsp.strobe) begin
         reply_status = STATUS_OK;
         reply_word   = bus_rsp.rdata;
      end else begin
         reply_status = STATUS_TIMEOUT;   // nobody decoded the address
         reply_word   = '0;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         byte_index <= '0;
         bytes_left <= '0;
      end else if (state == IDLE) begin
         byte_index <= '0;
         bytes_left <= COUNT_W'(CMD_BYTES);
      end else if (reply_load) begin
         byte_index <= '0;
         bytes_left <= COUNT_W'(REPLY_BYTES);
      end else if (byte_take || byte_give) begin
         byte_index <= byte_index + 1'b1;
         bytes_left <= bytes_left - 1'b1;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         timeout_cnt <= '0;
      end else if (state == ISSUE) begin
         timeout_cnt <= TIMEOUT_W'(TIMEOUT_COUNT);
      end else if ((state == WAIT_RSP) && !timeout_zero) begin
         timeout_cnt <= timeout_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (byte_take) begin
         cmd_packet[byte_index] <= up_data_in;
      end
      if (reply_load) begin
         reply_packet[STATUS_BYTE_IDX]     <= reply_status;
         reply_packet[STATUS_BYTE_IDX + 1] <= reply_word[7:0];   // lsb first
         reply_packet[STATUS_BYTE_IDX + 2] <= reply_word[15:8];
         reply_packet[STATUS_BYTE_IDX + 3] <= reply_word[23:16];
         reply_packet[STATUS_BYTE_IDX + 4] <= reply_word[31:24];
      end
      if (byte_give) begin
         data_out_q <= reply_packet[byte_index];   // held through REPLY_DROP
      end
   end

   always_comb begin
      bus_req.strobe = (state == ISSUE);            // exactly one cycle
      bus_req.op     = cmd.clear ? BUS_CLEAR : (cmd.write ? BUS_WRITE : BUS_READ);
      bus_req.addr   = reg_addr_t'(cmd_packet[ADDR_BYTE_IDX]);
      bus_req.wdata  = {cmd_packet[DATA_BYTE_IDX + 3], cmd_packet[DATA_BYTE_IDX + 2],
                        cmd_packet[DATA_BYTE_IDX + 1], cmd_packet[DATA_BYTE_IDX]};
   end

   assign up_data_out = data_out_q;
   assign up_data_oe  = up_ack && !up_rw;   // drive only in reply phase

   // slave plus collector always answer a fixed time after our strobe
   rsp_latency_a : assert property (
      @(posedge clk) disable iff (!reset)
      bus_rsp.strobe |-> $past(bus_req.strobe, BUS_LATENCY))
      else $error("bus response without request %0d cycles earlier", BUS_LATENCY);

endmodule

/* source/reg_slave.sv */
//**********************************************************
// one register slave, three r/w words and a write counter
// slave_index must be below NUM_SLAVES
// write to the counter index is acked and ignored
// a clear strobe zeroes all registers and is not acked
//**********************************************************

module reg_slave #(
   parameter int slave_index = 0
) (
   input  logic                    clk,
   input  logic                    reset,
   input  reg_bus_pkg::bus_req_t   bus_req,
   output reg_bus_pkg::slave_rsp_t rsp
);

   import reg_bus_pkg::*;

   logic [31:0] data_reg [3];
   logic [31:0] write_count;
   logic [31:0] rdata_q;
   logic        ack_q;
   logic        hit;         // read or write decoded for this slave
   logic        is_count;    // access to the counter index
   logic        is_write;
   logic        do_clear;

   assign hit = bus_req.strobe && (bus_req.addr.slave == 4'(slave_index)) &&
                (bus_req.addr.zero == 2'b00) &&
                ((bus_req.op == BUS_READ) || (bus_req.op == BUS_WRITE));
   assign is_count = (bus_req.addr.index == WCOUNT_INDEX);
   assign is_write = (bus_req.op == BUS_WRITE);
   assign do_clear = bus_req.strobe && (bus_req.op == BUS_CLEAR);   // broadcast

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         ack_q       <= 1'b0;
         write_count <= '0;
         data_reg    <= '{default: '0};
      end else if (do_clear) begin
         ack_q       <= 1'b0;
         write_count <= '0;
         data_reg    <= '{default: '0};
      end else begin
         ack_q <= hit;
         if (hit && is_write && !is_count) begin
            data_reg[bus_req.addr.index] <= bus_req.wdata;
            write_count                  <= write_count + 1'b1;
         end
      end
   end

   // reply holds the value after the access
   always_ff @(posedge clk) begin
      if (hit) begin
         if (is_count) begin
            rdata_q <= write_count;               // unchanged by this access
         end else if (is_write) begin
            rdata_q <= bus_req.wdata;             // echo of new value
         end else begin
            rdata_q <= data_reg[bus_req.addr.index];
         end
      end
   end

   assign rsp.ack   = ack_q;
   assign rsp.rdata = rdata_q;

endmodule

/* source/reg_response_collect.sv */
//**********************************************************
// merges the slave replies into one bus response
// one cycle of latency, at most one slave acks at a time
//**********************************************************

module reg_response_collect (
   input  logic                    clk,
   input  logic                    reset,
   input  reg_bus_pkg::slave_rsp_t slave_rsp [reg_bus_pkg::NUM_SLAVES],
   output reg_bus_pkg::bus_rsp_t   bus_rsp
);

   import reg_bus_pkg::*;

   logic [NUM_SLAVES-1:0] ack_vec;
   logic [31:0]           merged_rdata;   // data of the acking slave
   logic [31:0]           rdata_q;
   logic                  strobe_q;

   always_comb begin
      ack_vec      = '0;
      merged_rdata = '0;
      for (int i = 0; i < NUM_SLAVES; i++) begin
         ack_vec[i] = slave_rsp[i].ack;
         if (slave_rsp[i].ack) begin
            merged_rdata = slave_rsp[i].rdata;
         end
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= |ack_vec;
      end
   end

   always_ff @(posedge clk) begin
      if (|ack_vec) begin
         rdata_q <= merged_rdata;
      end
   end

   assign bus_rsp.strobe = strobe_q;
   assign bus_rsp.rdata  = rdata_q;

   // address decode across slaves must never overlap
   single_ack_a : assert property (
      @(posedge clk) disable iff (!reset) $onehot0(ack_vec))
      else $error("more than one slave acked: %b", ack_vec);

endmodule

/* source/up_bridge_top.sv */
//**********************************************************
// processor byte port to four register slaves
// data pin split into in, out and output enable
//**********************************************************

module up_bridge_top (
   input  logic       clk,
   input  logic       reset,
   input  logic       up_start,
   input  logic       up_handshake_1,
   input  logic       up_rw,
   input  logic [7:0] up_data_in,
   output logic [7:0] up_data_out,
   output logic       up_data_oe,
   output logic       up_ack,
   output logic       up_handshake_2
);

   import reg_bus_pkg::*;

   bus_req_t   bus_req;
   bus_rsp_t   bus_rsp;
   slave_rsp_t slave_rsp [NUM_SLAVES];

   up_interface u_master (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_rw          (up_rw),
      .up_data_in     (up_data_in),
      .up_data_out    (up_data_out),
      .up_data_oe     (up_data_oe),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2),
      .bus_req        (bus_req),
      .bus_rsp        (bus_rsp)
   );

   for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
      reg_slave #(.slave_index(i)) u_slave (
         .clk     (clk),
         .reset   (reset),
         .bus_req (bus_req),      // shared request, each decodes own field
         .rsp     (slave_rsp[i])
      );
   end

   reg_response_collect u_collect (
      .clk       (clk),
      .reset     (reset),
      .slave_rsp (slave_rsp),
      .bus_rsp   (bus_rsp)
   );

endmodule

/* verification/up_bridge_tb.sv */
//**********************************************************
// drives the processor byte port with LFSR stimulus, seed 37
// reference model keeps three words and a counter per slave
// run is limited to 200 transactions of up to 100 cycles
//**********************************************************

module up_bridge_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import up_link_pkg::*;
   import reg_bus_pkg::*;

   localparam int NUM_TRANSACTIONS = 200;
   localparam int CYCLES_PER_TRANS = 100;   // 11 bytes plus bus wait, with margin
   localparam int CYCLE_LIMIT      = NUM_TRANSACTIONS * CYCLES_PER_TRANS;

   logic        clk;
   logic        reset;
   logic        up_start;
   logic        up_handshake_1;
   logic        up_rw;
   logic [7:0]  up_data_in;
   logic [7:0]  up_data_out;
   logic        up_data_oe;
   logic        up_ack;
   logic        up_handshake_2;

   logic [15:0] lfsr_state;
   logic [31:0] model_regs [NUM_SLAVES][4];   // index 3 is the write counter
   int          pass_count;
   int          fail_count;
   int          protocol_errors;              // owned by the monitor
   int          cycle_count;
   int          hs2_rises;                    // command bytes seen before ack
   logic        hs1_prev;
   logic        hs2_prev;
   logic        ack_prev;

   up_bridge_top uut (
      .clk            (clk),
      .reset          (reset),
      .up_start       (up_start),
      .up_handshake_1 (up_handshake_1),
      .up_rw          (up_rw),
      .up_data_in     (up_data_in),
      .up_data_out    (up_data_out),
      .up_data_oe     (up_data_oe),
      .up_ack         (up_ack),
      .up_handshake_2 (up_handshake_2)
   );

   always #10 clk = ~clk;   // 20 ns period

   // taps 16,14,13,11, maximal length
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_step(lfsr_state);   // one step per bit
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   function automatic up_cmd_t make_cmd(input logic clear, input logic write);
      up_cmd_t c;
      c       = '0;
      c.clear = clear;
      c.write = write;
      return c;
   endfunction

   task automatic send_byte(input logic [7:0] b);
      up_data_in     = b;
      up_handshake_1 = 1'b1;
      while (!up_handshake_2) @(negedge clk);   // bridge took the byte
      up_handshake_1 = 1'b0;
      while (up_handshake_2) @(negedge clk);
   endtask

   task automatic receive_byte(output logic [7:0] b);
      up_handshake_1 = 1'b1;
      while (!up_handshake_2) @(negedge clk);
      if (!up_data_oe) begin
         $display("bridge did not enable its data output during a reply byte");
         fail_count++;
      end
      b              = up_data_out;             // stable while handshake_2 high
      up_handshake_1 = 1'b0;
      while (up_handshake_2) @(negedge clk);
   endtask

   task automatic run_transaction(input up_cmd_t cmd, input reg_addr_t addr,
                                  input logic [31:0] wdata,
                                  output up_status_t status, output logic [31:0] word);
      logic [7:0] packet [CMD_BYTES];
      logic [7:0] reply  [REPLY_BYTES];
      packet[0] = cmd;
      packet[1] = addr;
      packet[2] = wdata[7:0];                   // lsb first
      packet[3] = wdata[15:8];
      packet[4] = wdata[23:16];
      packet[5] = wdata[31:24];
      @(negedge clk);
      up_start = 1'b1;
      up_rw    = 1'b1;
      for (int i = 0; i < CMD_BYTES; i++) begin
         send_byte(packet[i]);
      end
      while (!up_ack) @(negedge clk);
      up_rw = 1'b0;                             // reply phase
      for (int i = 0; i < REPLY_BYTES; i++) begin
         receive_byte(reply[i]);
      end
      up_start = 1'b0;
      up_rw    = 1'b1;
      while (up_ack) @(negedge clk);
      status = up_status_t'(reply[0]);
      word   = {reply[4], reply[3], reply[2], reply[1]};
   endtask

   // expected reply from the register rules, model updated in place
   task automatic model_access(input up_cmd_t cmd, input reg_addr_t addr,
                               input logic [31:0] wdata,
                               output up_status_t status, output logic [31:0] word);
      int s;
      int r;
      s = int'(addr.slave);
      r = int'(addr.index);
      if (cmd.clear) begin
         model_regs = '{default: '{default: '0}};
         status     = STATUS_CLEAR_DONE;
         word       = '0;
      end else if ((s >= NUM_SLAVES) || (addr.zero != 2'b00)) begin
         status = STATUS_TIMEOUT;               // nobody answers
         word   = '0;
      end else if (cmd.write && (r == 3)) begin
         status = STATUS_OK;
         word   = model_regs[s][3];             // counter untouched
      end else if (cmd.write) begin
         model_regs[s][r] = wdata;
         model_regs[s][3] = model_regs[s][3] + 32'd1;
         status           = STATUS_OK;
         word             = wdata;
      end else begin
         status = STATUS_OK;
         word   = model_regs[s][r];
      end
   endtask

   task automatic check_status(input string name, input up_status_t expected,
                               input up_status_t actual);
      if (actual !== expected) begin
         $display("ERR %s status expected %02h actual %02h", name, expected, actual);
         fail_count++;
      end else begin
         $display("ok  %s status %02h", name, actual);
         pass_count++;
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s data expected %08h actual %08h", name, expected, actual);
         fail_count++;
      end else begin
         $display("ok  %s data %08h", name, actual);
         pass_count++;
      end
   endtask

   task automatic access_and_check(input string name, input up_cmd_t cmd,
                                   input reg_addr_t addr, input logic [31:0] wdata);
      up_status_t  exp_status;
      up_status_t  act_status;
      logic [31:0] exp_word;
      logic [31:0] act_word;
      model_access(cmd, addr, wdata, exp_status, exp_word);
      run_transaction(cmd, addr, wdata, act_status, act_word);
      check_status(name, exp_status, act_status);
      check_word(name, exp_word, act_word);
   endtask

   task automatic sweep_read(input string prefix);
      reg_addr_t addr;
      for (int s = 0; s < NUM_SLAVES; s++) begin
         for (int r = 0; r < 4; r++) begin
            addr = '{slave: 4'(s), zero: 2'b00, index: 2'(r)};
            access_and_check($sformatf("%s_s%0d_r%0d", prefix, s, r),
                             make_cmd(1'b0, 1'b0), addr, 32'h0);
         end
      end
   endtask

   // handshake order, sampled at the rising edge
   always @(posedge clk or negedge reset) begin
      if (!reset) begin
         hs1_prev  <= 1'b0;
         hs2_prev  <= 1'b0;
         ack_prev  <= 1'b0;
         hs2_rises <= 0;
      end else begin
         hs1_prev <= up_handshake_1;
         hs2_prev <= up_handshake_2;
         ack_prev <= up_ack;
         if (up_handshake_2 && !hs2_prev && !hs1_prev) begin
            $display("handshake_2 rose while handshake_1 was low");
            protocol_errors <= protocol_errors + 1;
         end
         if (up_ack && !ack_prev) begin
            if (hs2_rises != CMD_BYTES) begin
               $display("ack rose after %0d command bytes instead of %0d",
                        hs2_rises, CMD_BYTES);
               protocol_errors <= protocol_errors + 1;
            end
            hs2_rises <= 0;
         end else if (up_handshake_2 && !hs2_prev && !up_ack) begin
            hs2_rises <= hs2_rises + 1;   // one command byte done
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles without finishing", cycle_count);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      reg_addr_t addr;
      clk             = 1'b0;
      reset           = 1'b0;
      up_start        = 1'b0;
      up_handshake_1  = 1'b0;
      up_rw           = 1'b1;
      up_data_in      = 8'h00;
      lfsr_state      = 16'd37;
      model_regs      = '{default: '{default: '0}};
      pass_count      = 0;
      fail_count      = 0;
      protocol_errors = 0;
      cycle_count     = 0;
      repeat (2) @(negedge clk);
      reset = 1'b1;

      // write then read back one mapped register
      addr = '{slave: 4'(rand_bits(2)), zero: 2'b00, index: 2'(rand_bits(8) % 3)};
      access_and_check("write_echo", make_cmd(1'b0, 1'b1), addr, rand_bits(32));
      access_and_check("read_back", make_cmd(1'b0, 1'b0), addr, 32'h0);

      for (int i = 0; i < 150; i++) begin
         addr = '{slave: 4'(rand_bits(2)), zero: 2'b00, index: 2'(rand_bits(2))};
         access_and_check($sformatf("random_%0d", i), make_cmd(1'b0, rand_bits(1) == 1),
                          addr, rand_bits(32));
      end

      addr = '{slave: 4'(rand_bits(2)), zero: 2'b00, index: WCOUNT_INDEX};
      access_and_check("count_write", make_cmd(1'b0, 1'b1), addr, rand_bits(32));

      // unmapped slave, then mapped slave with nonzero field
      addr = '{slave: 4'(4 + rand_bits(3)), zero: 2'b00, index: 2'(rand_bits(2))};
      access_and_check("unmapped_slave", make_cmd(1'b0, 1'b1), addr, rand_bits(32));
      addr = '{slave: 4'(rand_bits(2)), zero: 2'(1 + rand_bits(8) % 3),
               index: 2'(rand_bits(2))};
      access_and_check("nonzero_field", make_cmd(1'b0, 1'b1), addr, rand_bits(32));
      sweep_read("after_unmapped");

      addr = '0;
      access_and_check("clear", make_cmd(1'b1, 1'b0), addr, 32'h0);
      sweep_read("after_clear");

      repeat (4) @(negedge clk);   // let the monitor see the last edges
      fail_count = fail_count + protocol_errors;
      $display("%0d checks passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* sim.f */
source/up_link_pkg.sv
source/reg_bus_pkg.sv
source/up_interface_fsm.sv
source/up_interface.sv
source/reg_slave.sv
source/reg_response_collect.sv
source/up_bridge_top.sv
verification/up_bridge_tb.sv

/* Makefile */
# Verilator build and run of the processor bridge testbench

VERILATOR ?= verilator
TOP       ?= up_bridge_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
